// File: game_pkg.sv
package game_pkg;

	// screen and sprite geometry in pixels
	localparam int screen_width = 640;
	localparam int screen_height = 480;
	localparam int sprite_size = 32; // bird is square

	// fixed point, 1/64 pixel resolution
	localparam int fixed_scale = 64; // power of two only
	localparam int fixed_shift = $clog2(fixed_scale); // divide by shifting
	localparam int step_unit = 16; // fixed-point units per speed step

	// rightmost legal top-left x, so the sprite stays on screen
	localparam int x_max = screen_width - sprite_size; // 608
	localparam int x_fp_max = x_max * fixed_scale;

	localparam int n_birds = 3;

	// random byte decision points
	localparam int right_threshold = 155; // above this the bird steps right
	localparam int left_threshold = 100; // below this the bird steps left

	localparam int red_frames = 32; // red time after a hit

	// frame lfsr, galois form shifting right
	localparam logic [23:0] lfsr_seed = 24'h00001F;
	localparam logic [23:0] lfsr_mask = 24'hE10000; // taps 24,23,22,17

	// signed screen coordinate
	typedef logic signed [10:0] coord_t;

	// start positions, one entry per bird
	localparam coord_t init_x [n_birds] = '{
		11'sd80,
		11'sd280,
		11'sd480
	};
	localparam coord_t init_y [n_birds] = '{
		11'sd40,
		11'sd120,
		11'sd200
	};

	// a point on screen, shot or scan position
	typedef struct packed {
		coord_t x;
		coord_t y;
	} point_t; // 22 bits

	// what every bird publishes to the arbiter
	typedef struct packed {
		point_t pos; // top-left corner in whole pixels
		logic alive; // life left or still flashing red
		logic red; // recently hit
	} bird_state_t; // 24 bits

endpackage

// File: frame_random.sv
`timescale 1ns/1ps

module frame_random (
	input logic clk,
	input logic resetN,
	input logic start_of_frame, // one step per frame
	output logic [23:0] rand_bytes // byte i goes to bird i
);

	logic [23:0] lfsr; // current lfsr state
	logic [23:0] lfsr_next;

	// galois step, shift right and fold the taps in when a one drops out
	always_comb begin
		lfsr_next = lfsr >> 1;
		if (lfsr[0]) begin
			lfsr_next = lfsr_next ^ game_pkg::lfsr_mask; // feedback
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			lfsr <= game_pkg::lfsr_seed; // nonzero seed, never locks up
		end else begin
			if (start_of_frame) begin
				lfsr <= lfsr_next; // advances at the end of the frame cycle
			end
		end
	end

	// the birds see the state of the frame cycle itself
	assign rand_bytes = lfsr;

endmodule

// File: bird_logic.sv
`timescale 1ns/1ps

module bird_logic #(
	parameter int bird_index = 0 // row of the start position tables
) (
	input logic clk,
	input logic resetN,
	input logic start_of_frame, // one-cycle pulse per frame
	input logic collision, // hit pulse from the arbiter
	input logic deploy, // level, looked at on frame pulses only
	input logic [7:0] random, // this bird's lfsr byte
	input logic [3:0] starting_life, // life loaded on deploy
	input logic [1:0] speed, // 0..3, step is (speed+1)*16/64 px
	output game_pkg::bird_state_t state
);

	logic [16:0] x_fp; // top-left x in 1/64 pixel units
	logic [3:0] life;
	logic [5:0] red_cnt; // frames left to show red
	logic hit_pending; // hit taken, charged on next frame
	logic red;
	logic [6:0] step; // fixed-point step, 16..64
	logic [17:0] x_sum; // one spare bit for the right step
	logic [16:0] x_right; // x after a right step, clamped
	logic [16:0] x_left; // x after a left step, clamped
	logic go_right;
	logic go_left;

	// start x of this bird in fixed point
	function automatic logic [16:0] home_x();
		home_x = 17'(game_pkg::init_x[bird_index]) << game_pkg::fixed_shift;
	endfunction

	assign step = 7'(({1'b0, speed} + 3'd1) * game_pkg::step_unit);

	// direction from the random byte, blocked at the screen edges
	assign go_right = (random > game_pkg::right_threshold)
		&& (x_fp < 17'(game_pkg::x_fp_max));
	assign go_left = (random < game_pkg::left_threshold)
		&& (x_fp != '0);

	// candidate positions, held inside 0..608 px
	assign x_sum = {1'b0, x_fp} + 18'(step);
	assign x_right = (x_sum > 18'(game_pkg::x_fp_max)) ?
		17'(game_pkg::x_fp_max) : x_sum[16:0];
	assign x_left = (x_fp > 17'(step)) ? x_fp - 17'(step) : '0;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			x_fp <= home_x();
			life <= '0; // not deployed yet
			red_cnt <= '0;
			hit_pending <= 1'b0;
		end else begin
			if (start_of_frame) begin
				// red time runs out first
				if (red_cnt != '0) begin
					red_cnt <= red_cnt - 6'd1;
				end
				if (deploy) begin
					life <= starting_life;
					x_fp <= home_x(); // back to start
					hit_pending <= 1'b0; // old hits are forgotten
				end else begin
					if (go_right) begin
						x_fp <= x_right;
					end else if (go_left) begin
						x_fp <= x_left;
					end
					// at most one life per frame, extra shots merged
					if (hit_pending && (life != '0)) begin
						life <= life - 4'd1;
						red_cnt <= 6'(game_pkg::red_frames); // overrides countdown
						hit_pending <= 1'b0;
					end
				end
			end
			if (collision) begin
				hit_pending <= 1'b1; // a new hit always wins
			end
		end
	end

	assign red = (red_cnt != '0);

	// whole pixels out, y never moves
	assign state = '{
		pos: '{
			x: game_pkg::coord_t'(x_fp >> game_pkg::fixed_shift),
			y: game_pkg::init_y[bird_index]
		},
		alive: (life != '0) || red, // keeps showing until red ends
		red: red
	};

endmodule

// File: bird_arbiter.sv
`timescale 1ns/1ps

module bird_arbiter (
	input logic clk,
	input logic resetN,
	input game_pkg::bird_state_t birds_state [game_pkg::n_birds],
	input logic shot, // one-cycle strobe
	input game_pkg::point_t shot_pos,
	input game_pkg::point_t pixel_pos, // video scan position every cycle
	output logic [game_pkg::n_birds-1:0] hit_onehot, // collision per bird
	output logic shot_hit, // registered one cycle after the shot
	output logic [1:0] hit_bird, // winner index or 0 on a miss
	output logic pixel_draw, // combinational
	output logic pixel_red // combinational red of the winner
);

	logic [game_pkg::n_birds-1:0] shot_cover; // birds under the shot
	logic [game_pkg::n_birds-1:0] shot_win; // lowest of them
	logic [game_pkg::n_birds-1:0] pix_cover; // birds under the scan
	logic [game_pkg::n_birds-1:0] pix_win;
	logic [game_pkg::n_birds-1:0] red_vec;

	// live bird rectangle test with pos <= p < pos + 32 on both axes
	function automatic logic covers(game_pkg::bird_state_t b, game_pkg::point_t p);
		covers = b.alive
			&& (p.x >= b.pos.x) && (p.x < b.pos.x + game_pkg::sprite_size)
			&& (p.y >= b.pos.y) && (p.y < b.pos.y + game_pkg::sprite_size);
	endfunction

	// keep only the lowest set bit for fixed priority
	function automatic logic [game_pkg::n_birds-1:0] lowest_one(
		input logic [game_pkg::n_birds-1:0] v
	);
		lowest_one = v & (~v + 1'b1);
	endfunction

	// one-hot to index
	function automatic logic [1:0] onehot_index(input logic [game_pkg::n_birds-1:0] v);
		logic [1:0] idx;
		idx = '0;
		for (int i = 0; i < game_pkg::n_birds; i++) begin
			if (v[i]) begin
				idx = idx | 2'(i);
			end
		end
		return idx;
	endfunction

	always_comb begin
		for (int i = 0; i < game_pkg::n_birds; i++) begin
			shot_cover[i] = covers(birds_state[i], shot_pos);
			pix_cover[i] = covers(birds_state[i], pixel_pos);
			red_vec[i] = birds_state[i].red;
		end
	end

	assign shot_win = lowest_one(shot_cover);
	assign pix_win = lowest_one(pix_cover);

	// pixel side stays combinational for the video path
	assign pixel_draw = |pix_cover;
	assign pixel_red = |(pix_win & red_vec); // follows the winner only

	// registered shot side where only the winning bird gets the pulse
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			hit_onehot <= '0;
			shot_hit <= 1'b0;
			hit_bird <= '0;
		end else begin
			hit_onehot <= shot ? shot_win : '0;
			shot_hit <= shot && (shot_cover != '0); // miss gives nothing
			hit_bird <= shot ? onehot_index(shot_win) : 2'd0;
		end
	end

endmodule

// File: bird_field.sv
`timescale 1ns/1ps

module bird_field (
	input logic clk,
	input logic resetN,
	input logic start_of_frame, // one-cycle pulse per frame
	input logic deploy, // sampled with the frame pulse
	input logic shot, // one-cycle strobe
	input logic [3:0] starting_life,
	input logic [1:0] speed,
	input game_pkg::point_t shot_pos,
	input game_pkg::point_t pixel_pos, // video scan position
	output game_pkg::bird_state_t birds_state [game_pkg::n_birds],
	output logic shot_hit,
	output logic [1:0] hit_bird,
	output logic pixel_draw,
	output logic pixel_red
);

	logic [23:0] rand_bytes; // one byte per bird
	logic [game_pkg::n_birds-1:0] hit_onehot; // arbiter to birds

	frame_random u_random (
		.clk(clk),
		.resetN(resetN),
		.start_of_frame(start_of_frame),
		.rand_bytes(rand_bytes)
	);

	// identical birds, start position picked by index
	for (genvar i = 0; i < game_pkg::n_birds; i++) begin : g_bird
		bird_logic #(
			.bird_index(i)
		) u_bird (
			.clk(clk),
			.resetN(resetN),
			.start_of_frame(start_of_frame),
			.collision(hit_onehot[i]), // only the winner sees a hit
			.deploy(deploy),
			.random(rand_bytes[8*i +: 8]), // own byte of the lfsr
			.starting_life(starting_life),
			.speed(speed),
			.state(birds_state[i])
		);
	end

	bird_arbiter u_arbiter (
		.clk(clk),
		.resetN(resetN),
		.birds_state(birds_state),
		.shot(shot),
		.shot_pos(shot_pos),
		.pixel_pos(pixel_pos),
		.hit_onehot(hit_onehot),
		.shot_hit(shot_hit),
		.hit_bird(hit_bird),
		.pixel_draw(pixel_draw),
		.pixel_red(pixel_red)
	);

endmodule

// File: bird_asserts.sv
`timescale 1ns/1ps

module bird_asserts (
	input logic clk,
	input logic resetN,
	input logic shot,
	input logic [game_pkg::n_birds-1:0] hit_onehot,
	input logic shot_hit,
	input logic pixel_draw,
	input logic pixel_red
);

	int fail_count = 0; // read by the testbench at the end

	a_one_winner: assert property (
		@(posedge clk) disable iff (!resetN) $onehot0(hit_onehot)
	) else begin
		fail_count++;
		$error("more than one bird got the same shot");
	end

	a_hit_after_shot: assert property (
		@(posedge clk) disable iff (!resetN) shot_hit |-> $past(shot)
	) else begin
		fail_count++;
		$error("shot_hit without a shot one cycle before");
	end

	a_red_needs_draw: assert property (
		@(posedge clk) disable iff (!resetN) pixel_red |-> pixel_draw
	) else begin
		fail_count++;
		$error("pixel_red set while nothing is drawn");
	end

endmodule

bind bird_arbiter bird_asserts u_asserts (
	.clk(clk),
	.resetN(resetN),
	.shot(shot),
	.hit_onehot(hit_onehot),
	.shot_hit(shot_hit),
	.pixel_draw(pixel_draw),
	.pixel_red(pixel_red)
);

// File: bird_checker.sv
`timescale 1ns/1ps

module bird_checker (
	input logic clk,
	input logic check_en, // expected values valid this edge
	input logic [8*16-1:0] test_name,
	input game_pkg::bird_state_t exp_birds [game_pkg::n_birds],
	input logic exp_shot_hit,
	input logic [1:0] exp_hit_bird,
	input logic exp_draw,
	input logic exp_red,
	input game_pkg::bird_state_t birds_state [game_pkg::n_birds],
	input logic shot_hit,
	input logic [1:0] hit_bird,
	input logic pixel_draw,
	input logic pixel_red,
	output int error_count,
	output int check_count
);

	// one bird state as readable text
	function automatic string format_bird(game_pkg::bird_state_t s);
		return $sformatf("x=%0d y=%0d alive=%b red=%b", s.pos.x, s.pos.y, s.alive, s.red);
	endfunction

	initial begin
		error_count = 0;
		check_count = 0;
	end

	// registered outputs read before this edge updates them
	always @(posedge clk) begin
		if (check_en) begin
			check_count++;
			for (int b = 0; b < game_pkg::n_birds; b++) begin
				if (birds_state[b] !== exp_birds[b]) begin
					error_count++;
					$display("mismatch %0s bird%0d expected %0s actual %0s",
						test_name, b, format_bird(exp_birds[b]),
						format_bird(birds_state[b]));
				end
			end
			if (shot_hit !== exp_shot_hit) begin
				error_count++;
				$display("mismatch %0s shot_hit expected %b actual %b",
					test_name, exp_shot_hit, shot_hit);
			end
			if (hit_bird !== exp_hit_bird) begin
				error_count++;
				$display("mismatch %0s hit_bird expected %0d actual %0d",
					test_name, exp_hit_bird, hit_bird);
			end
			if (pixel_draw !== exp_draw) begin
				error_count++;
				$display("mismatch %0s pixel_draw expected %b actual %b",
					test_name, exp_draw, pixel_draw);
			end
			if (pixel_red !== exp_red) begin
				error_count++;
				$display("mismatch %0s pixel_red expected %b actual %b",
					test_name, exp_red, pixel_red);
			end
		end
	end

endmodule

// File: tb_bird_field.sv
`timescale 1ns/1ps

module tb_bird_field;

	localparam int max_records = 64;
	localparam int name_chars = 16;

	typedef struct packed {
		logic frame;
		logic deploy;
		logic [3:0] life;
		logic [1:0] speed;
		logic shot;
		game_pkg::point_t shot_pos;
		game_pkg::point_t pixel_pos;
	} stim_t;

	typedef struct packed {
		game_pkg::bird_state_t [game_pkg::n_birds-1:0] birds;
		logic shot_hit;
		logic [1:0] hit_bird;
		logic draw;
		logic red;
	} expect_t;

	logic clk;
	logic resetN;
	logic start_of_frame;
	logic deploy;
	logic shot;
	logic [3:0] starting_life;
	logic [1:0] speed;
	game_pkg::point_t shot_pos;
	game_pkg::point_t pixel_pos;
	game_pkg::bird_state_t birds_state [game_pkg::n_birds];
	logic shot_hit;
	logic [1:0] hit_bird;
	logic pixel_draw;
	logic pixel_red;

	stim_t stim_mem [max_records]; // one entry per trace line
	expect_t exp_mem [max_records];
	int rep_mem [max_records]; // how often the stimulus repeats
	logic [8*name_chars-1:0] name_mem [max_records];
	int n_records;
	int total_steps; // repetitions over the whole trace
	int read_errors;
	logic loaded; // trace is in memory so the watchdog may start

	logic check_en; // expected values below are valid
	logic [8*name_chars-1:0] test_name;
	game_pkg::bird_state_t exp_birds [game_pkg::n_birds];
	logic exp_shot_hit;
	logic [1:0] exp_hit_bird;
	logic exp_draw;
	logic exp_red;
	int error_count;
	int check_count;

	bird_field dut (
		.clk(clk),
		.resetN(resetN),
		.start_of_frame(start_of_frame),
		.deploy(deploy),
		.shot(shot),
		.starting_life(starting_life),
		.speed(speed),
		.shot_pos(shot_pos),
		.pixel_pos(pixel_pos),
		.birds_state(birds_state),
		.shot_hit(shot_hit),
		.hit_bird(hit_bird),
		.pixel_draw(pixel_draw),
		.pixel_red(pixel_red)
	);

	bird_checker u_checker (
		.clk(clk),
		.check_en(check_en),
		.test_name(test_name),
		.exp_birds(exp_birds),
		.exp_shot_hit(exp_shot_hit),
		.exp_hit_bird(exp_hit_bird),
		.exp_draw(exp_draw),
		.exp_red(exp_red),
		.birds_state(birds_state),
		.shot_hit(shot_hit),
		.hit_bird(hit_bird),
		.pixel_draw(pixel_draw),
		.pixel_red(pixel_red),
		.error_count(error_count),
		.check_count(check_count)
	);

	always #4 clk = ~clk; // 8 ns period

	// load the whole trace and skip comment and blank lines
	task automatic read_trace();
		int fd;
		int code;
		string line;
		int v [26];
		logic [8*name_chars-1:0] nm;
		fd = $fopen("bird_trace.txt", "r");
		if (fd == 0) begin
			$display("cannot open bird_trace.txt");
			read_errors++;
			return;
		end
		while (!$feof(fd) && n_records < max_records) begin
			line = "";
			code = $fgets(line, fd);
			if (line.len() < 2 || line.substr(0, 0) == "#") begin
				continue;
			end
			code = $sscanf(line,
				"%s %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
				nm, v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
				v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18], v[19],
				v[20], v[21], v[22], v[23], v[24], v[25]);
			if (code != 27) begin
				$display("trace line %0d has %0d fields instead of 27", n_records, code);
				read_errors++;
				continue;
			end
			name_mem[n_records] = nm;
			rep_mem[n_records] = v[0];
			stim_mem[n_records] = '{frame: v[1][0], deploy: v[2][0], life: v[3][3:0],
				speed: v[4][1:0], shot: v[5][0],
				shot_pos: '{x: v[6][10:0], y: v[7][10:0]},
				pixel_pos: '{x: v[8][10:0], y: v[9][10:0]}};
			for (int b = 0; b < game_pkg::n_birds; b++) begin
				exp_mem[n_records].birds[b] = '{
					pos: '{x: v[10+4*b][10:0], y: v[11+4*b][10:0]},
					alive: v[12+4*b][0],
					red: v[13+4*b][0]
				};
			end
			exp_mem[n_records].shot_hit = v[22][0];
			exp_mem[n_records].hit_bird = v[23][1:0];
			exp_mem[n_records].draw = v[24][0];
			exp_mem[n_records].red = v[25][0];
			total_steps += v[0];
			n_records++;
		end
		$fclose(fd);
	endtask

	// watchdog whose limit grows with the trace length
	initial begin
		wait (loaded);
		repeat (total_steps * 3 + 100) @(posedge clk);
		$display("run timed out before the trace was finished");
		$display("Test FAILED");
		$finish;
	end

	initial begin
		int total_errors;
		clk = 1'b0;
		resetN = 1'b0;
		start_of_frame = 1'b0;
		deploy = 1'b0;
		shot = 1'b0;
		starting_life = '0;
		speed = '0;
		shot_pos = '0;
		pixel_pos = '0;
		check_en = 1'b0;
		test_name = '0;
		exp_shot_hit = 1'b0;
		exp_hit_bird = '0;
		exp_draw = 1'b0;
		exp_red = 1'b0;
		for (int b = 0; b < game_pkg::n_birds; b++) begin
			exp_birds[b] = '0;
		end
		n_records = 0;
		total_steps = 0;
		read_errors = 0;
		loaded = 1'b0;
		read_trace();
		loaded = 1'b1;
		repeat (5) @(posedge clk);
		@(negedge clk);
		resetN = 1'b1; // released between rising edges
		for (int i = 0; i < n_records; i++) begin
			for (int r = 0; r < rep_mem[i]; r++) begin
				@(negedge clk);
				check_en = 1'b0;
				start_of_frame = stim_mem[i].frame; // strobes last one cycle
				deploy = stim_mem[i].deploy;
				starting_life = stim_mem[i].life;
				speed = stim_mem[i].speed;
				shot = stim_mem[i].shot;
				shot_pos = stim_mem[i].shot_pos;
				pixel_pos = stim_mem[i].pixel_pos;
				@(negedge clk);
				start_of_frame = 1'b0;
				shot = 1'b0;
				if (r == rep_mem[i] - 1) begin
					test_name = name_mem[i]; // compared at the next rising edge
					for (int b = 0; b < game_pkg::n_birds; b++) begin
						exp_birds[b] = exp_mem[i].birds[b];
					end
					exp_shot_hit = exp_mem[i].shot_hit;
					exp_hit_bird = exp_mem[i].hit_bird;
					exp_draw = exp_mem[i].draw;
					exp_red = exp_mem[i].red;
					check_en = 1'b1;
				end
			end
		end
		@(negedge clk);
		check_en = 1'b0;
		@(negedge clk);
		total_errors = error_count + read_errors + dut.u_arbiter.u_asserts.fail_count;
		if (check_count == 0) begin
			$display("no comparison was made, trace is empty");
			total_errors++;
		end
		$display("checks %0d, compare errors %0d, trace errors %0d, assertion errors %0d",
			check_count, error_count, read_errors, dut.u_arbiter.u_asserts.fail_count);
		if (total_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// File: bird_trace.txt
# name rep frame deploy life speed shot shot_x shot_y pix_x pix_y, then per bird x y alive red, then shot_hit hit_bird draw red
# decimal fields; rep repeats the stimulus and the expected values hold after the last repeat
reset 1 0 0 0 0 0 0 0 90 50 80 40 0 0 280 120 0 0 480 200 0 0 0 0 0 0
deploy 1 1 1 2 3 0 0 0 90 50 80 40 1 0 280 120 1 0 480 200 1 0 0 0 1 0
move_s1 1 1 0 2 3 0 0 0 90 50 79 40 1 0 279 120 1 0 481 200 1 0 0 0 1 0
move_s2 1 1 0 2 1 0 0 0 90 50 78 40 1 0 279 120 1 0 481 200 1 0 0 0 1 0
move_s3 1 1 0 2 3 0 0 0 90 50 77 40 1 0 280 120 1 0 482 200 1 0 0 0 1 0
shot_b1 1 0 0 2 3 1 285 125 290 130 77 40 1 0 280 120 1 0 482 200 1 0 1 1 1 0
shot_again 1 0 0 2 3 1 300 140 290 130 77 40 1 0 280 120 1 0 482 200 1 0 1 1 1 0
hit_frame 1 1 0 2 3 0 0 0 290 130 76 40 1 0 281 120 1 1 483 200 1 0 0 0 1 1
miss 1 0 0 2 3 1 10 10 10 10 76 40 1 0 281 120 1 1 483 200 1 0 0 0 0 0
shot_red 1 0 0 2 3 1 290 130 290 130 76 40 1 0 281 120 1 1 483 200 1 0 1 1 1 1
kill_frame 1 1 0 2 3 0 0 0 290 130 75 40 1 0 282 120 1 1 484 200 1 0 0 0 1 1
red_decay 31 1 1 0 3 0 0 0 290 130 80 40 0 0 280 120 1 1 480 200 0 0 0 0 1 1
red_last 1 0 0 0 3 1 290 130 290 130 80 40 0 0 280 120 1 1 480 200 0 0 1 1 1 1
red_end 1 1 1 0 3 0 0 0 290 130 80 40 0 0 280 120 0 0 480 200 0 0 0 0 0 0
dead_shot 1 0 0 0 3 1 290 130 290 130 80 40 0 0 280 120 0 0 480 200 0 0 0 0 0 0
redeploy 1 1 1 3 3 0 0 0 490 210 80 40 1 0 280 120 1 0 480 200 1 0 0 0 1 0

// File: filelist.f
game_pkg.sv
frame_random.sv
bird_logic.sv
bird_arbiter.sv
bird_field.sv
bird_asserts.sv
bird_checker.sv
tb_bird_field.sv

// File: Bender.yml
package:
  name: bird_field

sources:
  - game_pkg.sv
  - frame_random.sv
  - bird_logic.sv
  - bird_arbiter.sv
  - bird_field.sv
  - target: simulation
    files:
      - bird_asserts.sv
      - bird_checker.sv
      - tb_bird_field.sv
